/* Bender.yml */
package:
  name: badge_soc_bus

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_pkg.sv
      - rtl/gpio_bank.sv
      - rtl/bus_decoder.sv
      - rtl/misc_regs.sv
      - rtl/local_ram.sv
      - rtl/fpga_reload_seq.sv
      - rtl/soc_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/soc_chk.sv
      - verification/soc_tb.sv

/* project.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/gpio_bank.sv
rtl/bus_decoder.sv
rtl/misc_regs.sv
rtl/local_ram.sv
rtl/fpga_reload_seq.sv
rtl/soc_top.sv
verification/soc_chk.sv
verification/soc_tb.sv

/* rtl/bus_decoder.sv */
// address decoder for the memory bus, routes selects, read data, ready and the bus-error irq
`timescale 1ns/1ps

`include "soc_params.svh"

module bus_decoder import soc_pkg::*; (
	input logic clk48m,
	input logic rst,
	input logic mem_valid,
	input word_t mem_addr,
	input word_t misc_rdata,
	input word_t ram_rdata,
	input logic ram_ready,
	output logic misc_sel,
	output logic ram_sel,
	output word_t mem_rdata,
	output logic mem_ready,
	output irq_vec_t irq
);

	region_e region;
	logic bus_error;

	assign region = region_e'(mem_addr[31:28]);

	always_comb begin
		misc_sel = 1'b0;
		ram_sel = 1'b0;
		bus_error = 1'b0;
		mem_rdata = `BUS_ERROR_DATA;
		case (region)
			REGION_MISC: begin
				misc_sel = mem_valid;
				mem_rdata = misc_rdata;
			end
			REGION_RAM: begin
				ram_sel = mem_valid;
				mem_rdata = ram_rdata;
			end
			default: begin
				// nothing lives here, answer at once with the error word
				bus_error = mem_valid;
			end
		endcase
	end

	// misc registers answer in the same cycle, so their select is their ready
	assign mem_ready = misc_sel | ram_ready | bus_error;

	// only the bus-error source is left in the irq vector
	always_comb begin
		irq = '0;
		irq[`IRQ_BUS_ERROR] = bus_error;
	end

endmodule

/* rtl/fpga_reload_seq.sv */
// flash-select clock pulse and delayed programn for switching boot flash and reloading the FPGA
`timescale 1ns/1ps

`include "soc_params.svh"

module fpga_reload_seq (
	input logic clk48m,
	input logic rst,
	input logic fsel_write,
	input logic reload_request,
	output logic fsel_c,
	output logic programn
);

	logic [2:0] fsel_delay;
	logic programn_queue;
	logic fpga_reload;

	// clock the select flip-flop well after fsel_d settles
	assign fsel_c = (fsel_delay == 3'd5) || (fsel_delay == 3'd4) || (fsel_delay == 3'd3);
	assign programn = ~fpga_reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay <= '0;
			programn_queue <= 1'b0;
			fpga_reload <= 1'b0;
		end else begin
			if (reload_request) begin
				programn_queue <= 1'b1;
			end
			if (fsel_write) begin
				fsel_delay <= `FSEL_DELAY_START;
			end else if (fsel_delay != 3'd0) begin
				fsel_delay <= fsel_delay - 3'd1;
				// the FPGA restarts from here, only reset brings programn back
				if (fsel_delay == 3'd1 && programn_queue) begin
					fpga_reload <= 1'b1;
				end
			end
		end
	end

endmodule

/* rtl/gpio_bank.sv */
// output and output-enable registers of one GPIO port, with write, write-to-set and write-to-clear
`timescale 1ns/1ps

module gpio_bank #(
	parameter type pins_t = logic [7:0]
) (
	input logic clk48m,
	input logic rst,
	input logic wr_out,
	input logic wr_oe,
	input logic wr_set,
	input logic wr_clr,
	input pins_t wdata,
	output pins_t pin_out,
	output pins_t pin_oe
);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			pin_out <= '0;
			pin_oe <= '0;
		end else begin
			// the strobes come from one register index, so at most one is high
			if (wr_out) begin
				pin_out <= wdata;
			end else if (wr_set) begin
				pin_out <= pin_out | wdata;
			end else if (wr_clr) begin
				pin_out <= pin_out & ~wdata;
			end
			if (wr_oe) begin
				pin_oe <= wdata;
			end
		end
	end

endmodule

/* rtl/local_ram.sv */
// local word RAM on the memory bus with byte strobes and one wait state
`timescale 1ns/1ps

`include "soc_params.svh"

module local_ram import soc_pkg::*; (
	input logic clk48m,
	input logic rst,
	input logic ram_sel,
	input word_t mem_addr,
	input word_t mem_wdata,
	input strb_t mem_wstrb,
	output word_t ram_rdata,
	output logic ram_ready
);

	localparam int ADDR_BITS = $clog2(`RAM_WORDS);

	word_t mem [0:`RAM_WORDS-1];
	logic [ADDR_BITS-1:0] word_idx;

	assign word_idx = mem_addr[ADDR_BITS+1:2];

	// ready follows the first cycle of select, then drops so a held select is not served twice
	always_ff @(posedge clk48m) begin
		if (rst) begin
			ram_ready <= 1'b0;
		end else begin
			ram_ready <= ram_sel && !ram_ready;
		end
	end

	// read in the wait cycle, write on the ready edge
	always_ff @(posedge clk48m) begin
		if (ram_sel && !ram_ready) begin
			ram_rdata <= mem[word_idx];
		end
		if (ram_sel && ram_ready) begin
			for (int b = 0; b < 4; b++) begin
				if (mem_wstrb[b]) begin
					mem[word_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

/* rtl/misc_regs.sv */
// misc register file on the memory bus: LEDs, buttons, version, trace, flash select and GPIO
`timescale 1ns/1ps

`include "soc_params.svh"

module misc_regs import soc_pkg::*; (
	input logic clk48m,
	input logic rst,
	input logic misc_sel,
	input word_t mem_addr,
	input word_t mem_wdata,
	input strb_t mem_wstrb,
	input logic [7:0] btn,
	input genio_t genio_in,
	input pmod_t pmod_in,
	output word_t misc_rdata,
	output logic [`LED_PINS-1:0] led,
	output logic trace_en,
	output logic fsel_d,
	output logic fsel_write,
	output logic reload_request,
	output genio_t genio_out,
	output genio_t genio_oe,
	output pmod_t pmod_out,
	output pmod_t pmod_oe
);

	misc_reg_e reg_idx;
	logic wr_en;
	logic [`LED_WIDTH-1:0] led_reg;

	assign reg_idx = misc_reg_e'(mem_addr[6:2]);

	// writes only look at strobe bit 0, firmware writes these registers as full words
	assign wr_en = misc_sel & mem_wstrb[0];

	// only the low LED bits reach the board
	assign led = led_reg[`LED_PINS-1:0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_reg <= '0;
			trace_en <= 1'b0;
			fsel_d <= 1'b0;
		end else if (wr_en) begin
			case (reg_idx)
				REG_LED: led_reg <= mem_wdata[`LED_WIDTH-1:0];
				REG_SOC_VER: trace_en <= mem_wdata[0];
				REG_FLASH_SEL: fsel_d <= mem_wdata[0];
				default: ;
			endcase
		end
	end

	// misc ready is immediate, so these last exactly one cycle
	assign fsel_write = wr_en && (reg_idx == REG_FLASH_SEL);
	assign reload_request = fsel_write && (mem_wdata[31:8] == `RELOAD_MAGIC);

	gpio_bank #(
		.pins_t(genio_t)
	) u_genio (
		.clk48m(clk48m),
		.rst(rst),
		.wr_out(wr_en && (reg_idx == REG_GENIO_OUT)),
		.wr_oe(wr_en && (reg_idx == REG_GENIO_OE)),
		.wr_set(wr_en && (reg_idx == REG_GENIO_W2S)),
		.wr_clr(wr_en && (reg_idx == REG_GENIO_W2C)),
		.wdata(mem_wdata[29:0]),
		.pin_out(genio_out),
		.pin_oe(genio_oe)
	);

	// pmod sits in bits 23:16 of the GPEXT registers
	gpio_bank #(
		.pins_t(pmod_t)
	) u_pmod (
		.clk48m(clk48m),
		.rst(rst),
		.wr_out(wr_en && (reg_idx == REG_GPEXT_OUT)),
		.wr_oe(wr_en && (reg_idx == REG_GPEXT_OE)),
		.wr_set(wr_en && (reg_idx == REG_GPEXT_W2S)),
		.wr_clr(wr_en && (reg_idx == REG_GPEXT_W2C)),
		.wdata(mem_wdata[23:16]),
		.pin_out(pmod_out),
		.pin_oe(pmod_oe)
	);

	// read-back mux, decoded from the address even without a select
	always_comb begin
		case (reg_idx)
			REG_LED: misc_rdata = word_t'(led_reg);
			// buttons are active low on the board
			REG_BTN: misc_rdata = {24'h0, ~btn};
			REG_SOC_VER: misc_rdata = `SOC_VERSION;
			REG_GENIO_IN: misc_rdata = {2'b00, genio_in};
			REG_GENIO_OUT: misc_rdata = {2'b00, genio_out};
			REG_GENIO_OE: misc_rdata = {2'b00, genio_oe};
			REG_GPEXT_IN: misc_rdata = {8'h0, pmod_in, 16'h0};
			REG_GPEXT_OUT: misc_rdata = {8'h0, pmod_out, 16'h0};
			REG_GPEXT_OE: misc_rdata = {8'h0, pmod_oe, 16'h0};
			default: misc_rdata = '0;
		endcase
	end

endmodule

/* rtl/soc_params.svh */
// shared constants for the badge system bus, included by the RTL and the testbench
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// version word returned by the SOC_VER register
`define SOC_VERSION 32'h0000_0100

// top 24 bits of a FLASH_SEL write that request an FPGA reload
`define RELOAD_MAGIC 24'hD0F1A5

// start count of the flash-select sequencer
// fsel_c is high while the count is 5, 4 or 3
`define FSEL_DELAY_START 3'd7

// depth of the local word RAM
`define RAM_WORDS 256

// irq vector bit raised on an access to an unmapped region
`define IRQ_BUS_ERROR 3

// read data returned from an unmapped address
`define BUS_ERROR_DATA 32'hDEAD_BEEF

// width of the LED register
`define LED_WIDTH 16

// number of LED pins on the board
`define LED_PINS 9

`endif

/* rtl/soc_pkg.sv */
// bus, region, register and pin types shared by the system-bus RTL
package soc_pkg;

	// memory bus word and byte-write strobe, an all-zero strobe is a read
	typedef logic [31:0] word_t;
	typedef logic [3:0] strb_t;

	// address bits 31:28, any other value is unmapped
	typedef enum logic [3:0] {
		REGION_MISC = 4'h2,
		REGION_RAM = 4'h4
	} region_e;

	// misc register index from address bits 6:2
	typedef enum logic [4:0] {
		REG_LED = 5'd0,
		REG_BTN = 5'd1,
		REG_SOC_VER = 5'd2,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_IN = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE = 5'd19,
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21,
		REG_GPEXT_IN = 5'd22,
		REG_GPEXT_OUT = 5'd23,
		REG_GPEXT_OE = 5'd24,
		REG_GPEXT_W2S = 5'd25,
		REG_GPEXT_W2C = 5'd26
	} misc_reg_e;

	typedef logic [29:0] genio_t;
	typedef logic [7:0] pmod_t;
	typedef logic [31:0] irq_vec_t;

endpackage

/* rtl/soc_top.sv */
// system-bus side of the badge SoC, an external master drives the valid/ready memory bus
`timescale 1ns/1ps

`include "soc_params.svh"

module soc_top import soc_pkg::*; (
	input logic clk48m,
	input logic rst,
	input logic mem_valid,
	input word_t mem_addr,
	input word_t mem_wdata,
	input strb_t mem_wstrb,
	output word_t mem_rdata,
	output logic mem_ready,
	output irq_vec_t irq,
	input logic [7:0] btn,
	output logic [`LED_PINS-1:0] led,
	input genio_t genio_in,
	output genio_t genio_out,
	output genio_t genio_oe,
	input pmod_t pmod_in,
	output pmod_t pmod_out,
	output pmod_t pmod_oe,
	output logic trace_en,
	output logic fsel_d,
	output logic fsel_c,
	output logic programn
);

	logic misc_sel;
	logic ram_sel;
	word_t misc_rdata;
	word_t ram_rdata;
	logic ram_ready;
	logic fsel_write;
	logic reload_request;

	bus_decoder u_bus_decoder (
		.clk48m(clk48m),
		.rst(rst),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.misc_rdata(misc_rdata),
		.ram_rdata(ram_rdata),
		.ram_ready(ram_ready),
		.misc_sel(misc_sel),
		.ram_sel(ram_sel),
		.mem_rdata(mem_rdata),
		.mem_ready(mem_ready),
		.irq(irq)
	);

	misc_regs u_misc_regs (
		.clk48m(clk48m),
		.rst(rst),
		.misc_sel(misc_sel),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.btn(btn),
		.genio_in(genio_in),
		.pmod_in(pmod_in),
		.misc_rdata(misc_rdata),
		.led(led),
		.trace_en(trace_en),
		.fsel_d(fsel_d),
		.fsel_write(fsel_write),
		.reload_request(reload_request),
		.genio_out(genio_out),
		.genio_oe(genio_oe),
		.pmod_out(pmod_out),
		.pmod_oe(pmod_oe)
	);

	// stands in for the cached PSRAM window
	local_ram u_local_ram (
		.clk48m(clk48m),
		.rst(rst),
		.ram_sel(ram_sel),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb),
		.ram_rdata(ram_rdata),
		.ram_ready(ram_ready)
	);

	fpga_reload_seq u_fpga_reload_seq (
		.clk48m(clk48m),
		.rst(rst),
		.fsel_write(fsel_write),
		.reload_request(reload_request),
		.fsel_c(fsel_c),
		.programn(programn)
	);

endmodule

/* verification/soc_chk.sv */
// concurrent assertions on the bus handshake and the reload sequencer, bound into the RTL below
`timescale 1ns/1ps

`include "soc_params.svh"

module soc_chk (
	input logic clk48m,
	input logic rst,
	input logic mem_valid,
	input logic mem_ready,
	input logic bus_irq,
	input logic fsel_c,
	input logic programn
);

	int fail_count = 0;

	ready_needs_valid: assert property (@(posedge clk48m) disable iff (rst)
		mem_ready |-> mem_valid)
		else begin
			$error("mem_ready high without mem_valid");
			fail_count++;
		end

	irq_with_ready: assert property (@(posedge clk48m) disable iff (rst)
		bus_irq |-> mem_ready)
		else begin
			$error("bus-error irq high without mem_ready");
			fail_count++;
		end

	fsel_c_window: assert property (@(posedge clk48m) disable iff (rst)
		fsel_c [*3] |=> !fsel_c)
		else begin
			$error("fsel_c high for more than three cycles");
			fail_count++;
		end

	// only reset brings programn back
	programn_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn |=> !programn)
		else begin
			$error("programn returned high without reset");
			fail_count++;
		end

endmodule

bind bus_decoder soc_chk u_bus_chk (
	.clk48m(clk48m),
	.rst(rst),
	.mem_valid(mem_valid),
	.mem_ready(mem_ready),
	.bus_irq(irq[`IRQ_BUS_ERROR]),
	.fsel_c(1'b0),
	.programn(1'b1)
);

bind fpga_reload_seq soc_chk u_seq_chk (
	.clk48m(clk48m),
	.rst(rst),
	.mem_valid(1'b0),
	.mem_ready(1'b0),
	.bus_irq(1'b0),
	.fsel_c(fsel_c),
	.programn(programn)
);

/* verification/soc_tb.sv */
// directed testbench for the badge system bus, drives the memory bus of soc_top and checks each block
`timescale 1ns/1ps

`include "soc_params.svh"

module soc_tb import soc_pkg::*; ();

	logic clk48m = 1'b0;
	logic rst;
	logic mem_valid;
	word_t mem_addr;
	word_t mem_wdata;
	strb_t mem_wstrb;
	word_t mem_rdata;
	logic mem_ready;
	irq_vec_t irq;
	logic [7:0] btn;
	logic [`LED_PINS-1:0] led;
	genio_t genio_in;
	genio_t genio_out;
	genio_t genio_oe;
	pmod_t pmod_in;
	pmod_t pmod_out;
	pmod_t pmod_oe;
	logic trace_en;
	logic fsel_d;
	logic fsel_c;
	logic programn;

	integer seed = 32'heb30_206a;
	int error_count;
	int test_count;
	int test_start_errors;
	// irq vector seen in the cycle where ready was high
	irq_vec_t ready_irq;

	soc_top uut (.*);

	always #20 clk48m = ~clk48m;

	function automatic word_t misc_addr(input misc_reg_e idx);
		return {4'h2, 21'h0, idx, 2'b00};
	endfunction

	function automatic word_t ram_addr(input logic [7:0] idx);
		return {4'h4, 18'h0, idx, 2'b00};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("ERR %s got %h expected %h", name, got, exp);
		error_count++;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name);
		$display("test %s done with %0d errors", name, error_count - test_start_errors);
		test_count++;
		test_start_errors = error_count;
	endtask

	// samples 3 ns after each edge, ends the request one edge after ready
	task automatic wait_ready(output word_t rdata);
		int cycles;
		cycles = 0;
		#1;
		while (mem_ready !== 1'b1 && cycles < 20) begin
			@(posedge clk48m);
			#3;
			cycles++;
		end
		if (mem_ready !== 1'b1) begin
			abort_on_timeout("mem_ready never came for the bus request");
		end else begin
			rdata = mem_rdata;
			ready_irq = irq;
			@(posedge clk48m);
			#2;
			mem_valid = 1'b0;
			mem_wstrb = '0;
		end
	endtask

	task automatic bus_write(input word_t addr, input word_t data, input strb_t strb);
		word_t unused;
		@(posedge clk48m);
		#2;
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = data;
		mem_wstrb = strb;
		wait_ready(unused);
	endtask

	task automatic bus_read(input word_t addr, output word_t data);
		@(posedge clk48m);
		#2;
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = '0;
		mem_wstrb = '0;
		wait_ready(data);
	endtask

	task automatic test_reset();
		#1;
		if (mem_ready !== 1'b0) report_mismatch("mem_ready", mem_ready, 0);
		if (irq !== '0) report_mismatch("irq", irq, 0);
		if (fsel_c !== 1'b0) report_mismatch("fsel_c", fsel_c, 0);
		if (trace_en !== 1'b0) report_mismatch("trace_en", trace_en, 0);
		if (programn !== 1'b1) report_mismatch("programn", programn, 1);
		if (led !== '0) report_mismatch("led", led, 0);
		if (genio_out !== '0) report_mismatch("genio_out", genio_out, 0);
		if (genio_oe !== '0) report_mismatch("genio_oe", genio_oe, 0);
		if (pmod_out !== '0) report_mismatch("pmod_out", pmod_out, 0);
		if (pmod_oe !== '0) report_mismatch("pmod_oe", pmod_oe, 0);
		if (fsel_d !== 1'b0) report_mismatch("fsel_d", fsel_d, 0);
		finish_test("reset");
	endtask

	task automatic test_ram();
		word_t expect_mem [8];
		word_t data;
		word_t wdata;
		for (int i = 0; i < 8; i++) begin
			expect_mem[i] = $random(seed);
			bus_write(ram_addr(i * 29 + 3), expect_mem[i], 4'hF);
		end
		for (int i = 0; i < 8; i++) begin
			bus_read(ram_addr(i * 29 + 3), data);
			if (data !== expect_mem[i]) report_mismatch("mem_rdata", data, expect_mem[i]);
		end
		// a write with only byte 2 strobed
		wdata = $random(seed);
		bus_write(ram_addr(3), wdata, 4'b0100);
		expect_mem[0] = (expect_mem[0] & 32'hFF00_FFFF) | (wdata & 32'h00FF_0000);
		bus_read(ram_addr(3), data);
		if (data !== expect_mem[0]) report_mismatch("mem_rdata", data, expect_mem[0]);
		finish_test("ram");
	endtask

	task automatic test_led_btn_ver();
		word_t data;
		word_t rd;
		data = $random(seed);
		bus_write(misc_addr(REG_LED), data, 4'hF);
		if (led !== data[`LED_PINS-1:0]) report_mismatch("led", led, data[`LED_PINS-1:0]);
		bus_read(misc_addr(REG_LED), rd);
		if (rd !== {16'h0, data[15:0]}) report_mismatch("mem_rdata", rd, {16'h0, data[15:0]});
		btn = $random(seed);
		bus_read(misc_addr(REG_BTN), rd);
		if (rd !== {24'h0, ~btn}) report_mismatch("mem_rdata", rd, {24'h0, ~btn});
		bus_read(misc_addr(REG_SOC_VER), rd);
		if (rd !== `SOC_VERSION) report_mismatch("mem_rdata", rd, `SOC_VERSION);
		bus_write(misc_addr(REG_SOC_VER), 32'h1, 4'hF);
		if (trace_en !== 1'b1) report_mismatch("trace_en", trace_en, 1);
		finish_test("led_btn_ver");
	endtask

	task automatic test_gpio();
		genio_t exp_out;
		pmod_t exp_pmod;
		word_t data;
		word_t rd;
		data = $random(seed);
		exp_out = data[29:0];
		bus_write(misc_addr(REG_GENIO_OUT), data, 4'hF);
		data = $random(seed);
		exp_out = exp_out | data[29:0];
		bus_write(misc_addr(REG_GENIO_W2S), data, 4'hF);
		data = $random(seed);
		exp_out = exp_out & ~data[29:0];
		bus_write(misc_addr(REG_GENIO_W2C), data, 4'hF);
		if (genio_out !== exp_out) report_mismatch("genio_out", genio_out, exp_out);
		bus_read(misc_addr(REG_GENIO_OUT), rd);
		if (rd !== {2'b00, exp_out}) report_mismatch("mem_rdata", rd, {2'b00, exp_out});
		data = $random(seed);
		bus_write(misc_addr(REG_GENIO_OE), data, 4'hF);
		if (genio_oe !== data[29:0]) report_mismatch("genio_oe", genio_oe, data[29:0]);
		// the PMOD port takes bits 23:16 of the bus word
		data = $random(seed);
		exp_pmod = data[23:16];
		bus_write(misc_addr(REG_GPEXT_OUT), data, 4'hF);
		data = $random(seed);
		exp_pmod = exp_pmod | data[23:16];
		bus_write(misc_addr(REG_GPEXT_W2S), data, 4'hF);
		data = $random(seed);
		exp_pmod = exp_pmod & ~data[23:16];
		bus_write(misc_addr(REG_GPEXT_W2C), data, 4'hF);
		if (pmod_out !== exp_pmod) report_mismatch("pmod_out", pmod_out, exp_pmod);
		bus_read(misc_addr(REG_GPEXT_OUT), rd);
		if (rd !== {8'h0, exp_pmod, 16'h0})
			report_mismatch("mem_rdata", rd, {8'h0, exp_pmod, 16'h0});
		data = $random(seed);
		bus_write(misc_addr(REG_GPEXT_OE), data, 4'hF);
		if (pmod_oe !== data[23:16]) report_mismatch("pmod_oe", pmod_oe, data[23:16]);
		genio_in = $random(seed);
		pmod_in = $random(seed);
		bus_read(misc_addr(REG_GENIO_IN), rd);
		if (rd !== {2'b00, genio_in}) report_mismatch("mem_rdata", rd, {2'b00, genio_in});
		bus_read(misc_addr(REG_GPEXT_IN), rd);
		if (rd !== {8'h0, pmod_in, 16'h0})
			report_mismatch("mem_rdata", rd, {8'h0, pmod_in, 16'h0});
		finish_test("gpio");
	endtask

	task automatic test_bus_error();
		word_t rd;
		bus_read(32'h9000_0010, rd);
		if (rd !== `BUS_ERROR_DATA) report_mismatch("mem_rdata", rd, `BUS_ERROR_DATA);
		if (ready_irq !== (32'h1 << `IRQ_BUS_ERROR))
			report_mismatch("irq", ready_irq, 32'h1 << `IRQ_BUS_ERROR);
		#1;
		if (irq !== '0) report_mismatch("irq", irq, 0);
		finish_test("bus_error");
	endtask

	task automatic test_reload();
		int cycles;
		logic exp_c;
		// the write task returns 2 ns after the accepting edge
		bus_write(misc_addr(REG_FLASH_SEL), 32'h1, 4'hF);
		if (fsel_d !== 1'b1) report_mismatch("fsel_d", fsel_d, 1);
		#1;
		for (int k = 0; k < 8; k++) begin
			exp_c = (k >= 2) && (k <= 4);
			if (fsel_c !== exp_c) report_mismatch("fsel_c", fsel_c, exp_c);
			if (programn !== 1'b1) report_mismatch("programn", programn, 1);
			@(posedge clk48m);
			#3;
		end
		bus_write(misc_addr(REG_FLASH_SEL), {`RELOAD_MAGIC, 8'h01}, 4'hF);
		cycles = 0;
		#1;
		while (programn === 1'b1 && cycles < 20) begin
			@(posedge clk48m);
			#3;
			cycles++;
		end
		if (programn === 1'b1) begin
			abort_on_timeout("programn never fell after the reload request");
		end else begin
			if (cycles != 7) report_mismatch("programn_delay", cycles, 7);
			finish_test("reload");
		end
	endtask

	initial begin
		rst = 1'b1;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		btn = '0;
		genio_in = '0;
		pmod_in = '0;
		error_count = 0;
		test_count = 0;
		test_start_errors = 0;
		repeat (5) @(posedge clk48m);
		#2;
		rst = 1'b0;
		test_reset();
		test_ram();
		test_led_btn_ver();
		test_gpio();
		test_bus_error();
		test_reload();
		// failed assertions of the bound checkers count as errors too
		error_count += uut.u_bus_decoder.u_bus_chk.fail_count;
		error_count += uut.u_fpga_reload_seq.u_seq_chk.fail_count;
		$display("tests run %0d, errors %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
